/* sim.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/regFile.sv
verilog/forwardUnit.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/pipeCore.sv
bench/pipeCoreTb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pipeCore testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module pipeCoreTb

status=0
./obj_dir/VpipeCoreTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0

/* bench/pipeCoreTb.sv */
// pipeCoreTb
// Random instruction stream into the five-stage core. An in-order
// register model predicts every write, and each write is due a
// fixed latency after its strobe

`timescale 1ns/1ps
`include "core_settings.svh"

module pipeCoreTb;
    import isaPkg::*;

    localparam int RANDOM_CYCLES = 2000;
    localparam int DRAIN_LIMIT   = 50;

    typedef struct packed {
        logic [31:0] due;   // Cycle count when wbStrobe is expected
        regAddrT     addr;
        wordT        data;
    } expWriteT;

    logic    clock;
    logic    arstN;
    logic    inStrobe;
    instrT   inInstr;
    logic    wbStrobe;
    regAddrT wbAddr;
    wordT    wbData;

    int       cycle = 0;
    int       writeCount = 0;
    int       waitCount;
    wordT     modelRegs [`CORE_NREGS];
    expWriteT expQ [$];

    functT  rFuncts [7] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
    opcodeT iOps [6]    = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI};
    opcodeT badOps [4]  = '{6'h02, 6'h04, 6'h23, 6'h2B};   // Jump, branch, load, store

    pipeCore u_dut (
        .clock(clock), .arstN(arstN), .inStrobe(inStrobe), .inInstr(inInstr),
        .wbStrobe(wbStrobe), .wbAddr(wbAddr), .wbData(wbData)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock)
        cycle <= cycle + 1;

    // Error handling ---------------------
    task automatic stopOnError(string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            stopOnError($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                  $time, name, got, exp));
    endtask

    // Instruction encoding ---------------
    function automatic instrT rType(functT fn, regAddrT rs, regAddrT rt, regAddrT rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instrT iType(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Registers 0 to 7 only, so hazards are dense
    function automatic instrT randomInstr();
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        logic [15:0] imm;
        int unsigned pick;

        rs   = regAddrT'($urandom_range(7));
        rt   = regAddrT'($urandom_range(7));
        rd   = regAddrT'($urandom_range(7));
        imm  = 16'($urandom);
        pick = $urandom_range(99);
        if (pick < 3)
            return iType(badOps[2'($urandom_range(3))], rs, rt, imm);
        else if (pick < 50)
            return rType(rFuncts[3'($urandom_range(6))], rs, rt, rd);
        else
            return iType(iOps[3'($urandom_range(5))], rs, rt, imm);
    endfunction

    // Reference model, one instruction at a time in program order
    task automatic modelExecute(instrT instr);
        opcodeT   op;
        functT    fn;
        regAddrT  rs;
        regAddrT  rt;
        regAddrT  dest;
        wordT     a;
        wordT     b;
        wordT     sImm;
        wordT     zImm;
        wordT     res;
        logic     known;
        expWriteT item;

        op    = instr[31:26];
        rs    = instr[25:21];
        rt    = instr[20:16];
        fn    = instr[5:0];
        a     = modelRegs[rs];
        b     = modelRegs[rt];
        sImm  = {{16{instr[15]}}, instr[15:0]};
        zImm  = {16'h0000, instr[15:0]};
        dest  = rt;         // I-type writes rt
        known = 1'b1;
        res   = '0;
        case (op)
            OP_RTYPE:
            begin
                dest = instr[15:11];
                case (fn)
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI: res = a + sImm;
            OP_SLTI: res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            OP_ANDI: res = a & zImm;
            OP_ORI:  res = a | zImm;
            OP_XORI: res = a ^ zImm;
            OP_LUI:  res = {instr[15:0], 16'h0000};
            default: known = 1'b0;
        endcase

        if (known && (dest != '0))
        begin
            modelRegs[dest] = res;
            item.due  = 32'(cycle + `CORE_WB_LATENCY);
            item.addr = dest;
            item.data = res;
            expQ.push_back(item);
        end
    endtask

    // Stimulus helpers ---------------------
    task automatic nextCycle();
        @(posedge clock);
        #2;
    endtask

    task automatic issue(instrT instr);
        inStrobe = 1'b1;
        inInstr  = instr;
        modelExecute(instr);
    endtask

    task automatic idle();
        inStrobe = 1'b0;
        inInstr  = $urandom;   // Junk, must be ignored
    endtask

    task automatic checkWriteback();
        expWriteT head;

        if ((expQ.size() != 0) && (expQ[0].due == 32'(cycle)))
        begin
            head = expQ.pop_front();
            compare("wbStrobe", 32'(wbStrobe), 32'd1);
            compare("wbAddr", 32'(wbAddr), 32'(head.addr));
            compare("wbData", wbData, head.data);
            writeCount++;
        end
        else
            compare("wbStrobe", 32'(wbStrobe), 32'd0);   // Bubbles and r0 stay silent
    endtask

    // Outputs settle long before the falling edge
    always @(negedge clock)
        checkWriteback();

    initial
    begin
        arstN    = 1'b0;
        inStrobe = 1'b0;
        inInstr  = '0;
        for (int i = 0; i < `CORE_NREGS; i++)
            modelRegs[i] = '0;
        void'($urandom(39119));

        repeat (10) @(posedge clock);
        #2;
        arstN = 1'b1;

        // Directed hazards -----------------
        nextCycle(); issue(iType(OP_ADDI, 5'd0, 5'd1, 16'h1234));
        nextCycle(); issue(iType(OP_ADDI, 5'd1, 5'd2, 16'hFFFF));  // E2 forward
        nextCycle(); issue(rType(FN_ADD, 5'd1, 5'd2, 5'd3));       // M and E2
        nextCycle(); issue(rType(FN_SUB, 5'd1, 5'd3, 5'd4));       // r1 from W
        nextCycle(); issue(rType(FN_OR, 5'd1, 5'd2, 5'd5));        // r1 via decode bypass
        nextCycle(); issue(iType(OP_LUI, 5'd0, 5'd1, 16'hABCD));
        nextCycle(); issue(iType(OP_ORI, 5'd1, 5'd1, 16'h5678));
        nextCycle(); issue(rType(FN_XOR, 5'd1, 5'd1, 5'd6));       // Youngest r1 wins
        nextCycle(); issue(iType(OP_ADDI, 5'd1, 5'd0, 16'h0077));  // Write to r0
        nextCycle(); issue(rType(FN_ADD, 5'd0, 5'd1, 5'd7));       // r0 reads zero
        nextCycle(); issue(iType(6'h23, 5'd1, 5'd2, 16'h0004));    // Unknown opcode
        nextCycle(); issue(rType(FN_SLT, 5'd2, 5'd1, 5'd3));
        nextCycle(); idle();
        nextCycle(); idle();
        nextCycle(); issue(rType(FN_NOR, 5'd3, 5'd0, 5'd4));

        // Random stream with gaps
        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            nextCycle();
            if ($urandom_range(99) < 75)
                issue(randomInstr());
            else
                idle();
        end
        nextCycle();
        idle();

        waitCount = 0;
        while ((expQ.size() != 0) && (waitCount < DRAIN_LIMIT))
        begin
            nextCycle();
            waitCount++;
        end
        repeat (`CORE_WB_LATENCY + 2) nextCycle();   // Nothing late may follow

        $display("%0d writebacks checked", writeCount);
        if (expQ.size() != 0)
            stopOnError("Timeout while waiting for the last writebacks");
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* verilog/pipeCore.sv */
// pipeCore
// Five-stage in-order integer core. D, E1, E2, M, W with
// full forwarding, so the pipeline never stalls

`timescale 1ns/1ps
`include "core_settings.svh"

module pipeCore (
    input  logic            clock,
    input  logic            arstN,
    input  logic            inStrobe,
    input  isaPkg::instrT   inInstr,
    output logic            wbStrobe,
    output isaPkg::regAddrT wbAddr,
    output isaPkg::wordT    wbData
);
    import isaPkg::*;
    import pipePkg::*;

    regAddrT   decRsAddr;
    regAddrT   decRtAddr;
    wordT      rfDataA;
    wordT      rfDataB;
    logic      bypassA;
    logic      bypassB;
    fwdSelT    fwdSelA;
    fwdSelT    fwdSelB;
    decodedOpT exOp;
    resultT    e2Res;
    resultT    mRes;
    resultT    wRes;

    decodeStage u_decode (
        .clock(clock), .arstN(arstN), .inStrobe(inStrobe), .inInstr(inInstr),
        .rsAddr(decRsAddr), .rtAddr(decRtAddr), .rsData(rfDataA), .rtData(rfDataB),
        .bypassA(bypassA), .bypassB(bypassB), .wData(wRes.data), .exOp(exOp)
    );

    executeStage u_execute (
        .clock(clock), .arstN(arstN), .exOp(exOp), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
        .mData(mRes.data), .wData(wRes.data), .e2Res(e2Res)
    );

    resultStage u_result (
        .clock(clock), .arstN(arstN), .e2Res(e2Res), .mRes(mRes), .wRes(wRes),
        .wbStrobe(wbStrobe), .wbAddr(wbAddr), .wbData(wbData)
    );

    // W write port is the writeback report itself
    regFile u_regs (
        .clock(clock), .arstN(arstN), .rdAddrA(decRsAddr), .rdAddrB(decRtAddr),
        .rdDataA(rfDataA), .rdDataB(rfDataB),
        .wrEn(wbStrobe), .wrAddr(wbAddr), .wrData(wbData)
    );

    forwardUnit u_forward (
        .decRsAddr(decRsAddr), .decRtAddr(decRtAddr), .exOp(exOp),
        .e2Res(e2Res), .mRes(mRes), .wRes(wRes),
        .fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .bypassA(bypassA), .bypassB(bypassB)
    );

    // Every writeback traces back to a strobe exactly one latency earlier
    a_wbLatency: assert property (@(posedge clock) disable iff (!arstN)
        wbStrobe |-> $past(inStrobe, `CORE_WB_LATENCY))
        else $error("pipeCore: writeback without matching strobe");

endmodule

/* verilog/resultStage.sv */
// resultStage
// Carries results through the M and W stages. W drives the
// register file write and the writeback report

`timescale 1ns/1ps

module resultStage (
    input  logic            clock,
    input  logic            arstN,
    input  pipePkg::resultT e2Res,
    output pipePkg::resultT mRes,
    output pipePkg::resultT wRes,
    output logic            wbStrobe,
    output isaPkg::regAddrT wbAddr,
    output isaPkg::wordT    wbData
);
    import pipePkg::*;

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            mRes <= '0;
            wRes <= '0;
        end
        else
        begin
            mRes <= e2Res;
            wRes <= mRes;
        end
    end

    assign wbStrobe = wRes.valid && wRes.writeEn;   // Decode already dropped rd 0
    assign wbAddr   = wRes.destAddr;
    assign wbData   = wRes.data;

    a_noWbZero: assert property (@(posedge clock) disable iff (!arstN)
        wbStrobe |-> (wbAddr != '0))
        else $error("resultStage: writeback to register 0");

endmodule

/* verilog/executeStage.sv */
// executeStage
// E1 operand selection from the decode value or a forwarded
// result, followed by the ALU. The result is registered
// into E2

`timescale 1ns/1ps
`include "core_settings.svh"

module executeStage (
    input  logic               clock,
    input  logic               arstN,
    input  pipePkg::decodedOpT exOp,
    input  pipePkg::fwdSelT    fwdSelA,
    input  pipePkg::fwdSelT    fwdSelB,
    input  isaPkg::wordT       mData,
    input  isaPkg::wordT       wData,
    output pipePkg::resultT    e2Res
);
    import isaPkg::*;
    import pipePkg::*;

    wordT opA;
    wordT srcB;     // Register side of operand B
    wordT opB;
    wordT aluOut;

    // Operand muxes ------------------------
    always_comb
    begin
        case (fwdSelA)
            FWD_E2:  opA = e2Res.data;
            FWD_M:   opA = mData;
            FWD_W:   opA = wData;
            default: opA = exOp.rsData;
        endcase

        case (fwdSelB)
            FWD_E2:  srcB = e2Res.data;
            FWD_M:   srcB = mData;
            FWD_W:   srcB = wData;
            default: srcB = exOp.rtData;
        endcase
    end

    assign opB = exOp.useImm ? exOp.imm : srcB;

    // ALU ----------------------------------
    always_comb
    begin
        case (exOp.aluOp)
            ALU_ADD: aluOut = opA + opB;
            ALU_SUB: aluOut = opA - opB;
            ALU_AND: aluOut = opA & opB;
            ALU_OR:  aluOut = opA | opB;
            ALU_XOR: aluOut = opA ^ opB;
            ALU_NOR: aluOut = ~(opA | opB);
            ALU_SLT: aluOut = wordT'($signed(opA) < $signed(opB));   // Signed compare
            ALU_LUI: aluOut = {opB[15:0], {(`CORE_XLEN-16){1'b0}}};
            default: aluOut = '0;
        endcase
    end

    // E1 to E2 register
    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            e2Res <= '0;
        end
        else
        begin
            e2Res.valid    <= exOp.valid;
            e2Res.writeEn  <= exOp.writeEn;
            e2Res.destAddr <= exOp.destAddr;
            e2Res.data     <= aluOut;
        end
    end

endmodule

/* verilog/decodeStage.sv */
// decodeStage
// Holds the strobed instruction for one cycle, splits its
// fields, maps opcode and function to an ALU operation and
// reads the operands, taking W data on a bypass. The decoded
// op is registered into E1

`timescale 1ns/1ps
`include "core_settings.svh"

module decodeStage (
    input  logic               clock,
    input  logic               arstN,
    input  logic               inStrobe,
    input  isaPkg::instrT      inInstr,
    output isaPkg::regAddrT    rsAddr,
    output isaPkg::regAddrT    rtAddr,
    input  isaPkg::wordT       rsData,
    input  isaPkg::wordT       rtData,
    input  logic               bypassA,
    input  logic               bypassB,
    input  isaPkg::wordT       wData,
    output pipePkg::decodedOpT exOp
);
    import isaPkg::*;
    import pipePkg::*;

    logic      dValid;
    instrT     dInstr;
    opcodeT    opcode;
    functT     funct;
    regAddrT   rdAddr;
    immT       imm16;
    logic      known;   // Legal opcode and function
    decodedOpT dOp;

    // D register ---------------------------
    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
            dValid <= 1'b0;
        else
            dValid <= inStrobe;
    end

    always_ff @(posedge clock)
    begin
        if (inStrobe)
            dInstr <= inInstr;
    end

    assign opcode = dInstr[31:26];
    assign rsAddr = dInstr[25:21];
    assign rtAddr = dInstr[20:16];
    assign rdAddr = dInstr[15:11];
    assign funct  = dInstr[5:0];
    assign imm16  = dInstr[15:0];

    // Decode -------------------------------
    always_comb
    begin
        known        = 1'b1;
        dOp          = '0;
        dOp.valid    = dValid;
        dOp.rsAddr   = rsAddr;
        dOp.rtAddr   = rtAddr;
        dOp.rsData   = bypassA ? wData : rsData;
        dOp.rtData   = bypassB ? wData : rtData;
        dOp.useImm   = 1'b1;   // I-type unless R-type below
        dOp.destAddr = rtAddr;
        dOp.imm      = {{(`CORE_XLEN-16){imm16[15]}}, imm16};
        dOp.aluOp    = ALU_ADD;

        case (opcode)
            OP_RTYPE:
            begin
                dOp.useImm   = 1'b0;
                dOp.destAddr = rdAddr;
                case (funct)
                    FN_ADD:  dOp.aluOp = ALU_ADD;
                    FN_SUB:  dOp.aluOp = ALU_SUB;
                    FN_AND:  dOp.aluOp = ALU_AND;
                    FN_OR:   dOp.aluOp = ALU_OR;
                    FN_XOR:  dOp.aluOp = ALU_XOR;
                    FN_NOR:  dOp.aluOp = ALU_NOR;
                    FN_SLT:  dOp.aluOp = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI: dOp.aluOp = ALU_ADD;
            OP_SLTI: dOp.aluOp = ALU_SLT;
            OP_ANDI:
            begin
                dOp.aluOp = ALU_AND;
                dOp.imm   = wordT'(imm16);  // Logical ops zero extend
            end
            OP_ORI:
            begin
                dOp.aluOp = ALU_OR;
                dOp.imm   = wordT'(imm16);
            end
            OP_XORI:
            begin
                dOp.aluOp = ALU_XOR;
                dOp.imm   = wordT'(imm16);
            end
            OP_LUI:
            begin
                dOp.aluOp = ALU_LUI;
                dOp.imm   = wordT'(imm16);
            end
            default: known = 1'b0;
        endcase

        dOp.writeEn = dValid && known && (dOp.destAddr != '0);
    end

    // D to E1 register
    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
            exOp <= '0;
        else
            exOp <= dOp;
    end

endmodule

/* verilog/forwardUnit.sv */
// forwardUnit
// Hazard detection for the E1 operands and the decode read.
// E1 takes the youngest pending write, E2 before M before W.
// Decode takes W data when it reads the register W is writing

`timescale 1ns/1ps

module forwardUnit (
    input  isaPkg::regAddrT    decRsAddr,
    input  isaPkg::regAddrT    decRtAddr,
    input  pipePkg::decodedOpT exOp,
    input  pipePkg::resultT    e2Res,
    input  pipePkg::resultT    mRes,
    input  pipePkg::resultT    wRes,
    output pipePkg::fwdSelT    fwdSelA,
    output pipePkg::fwdSelT    fwdSelB,
    output logic               bypassA,
    output logic               bypassB
);
    import isaPkg::*;
    import pipePkg::*;

    // True when the stage holds a real write to addr
    // writeEn is already low for destination 0
    function automatic logic writes(resultT res, regAddrT addr);
        return res.valid && res.writeEn && (res.destAddr == addr);
    endfunction

    always_comb
    begin
        fwdSelA = FWD_REG;
        fwdSelB = FWD_REG;

        if (writes(e2Res, exOp.rsAddr))
            fwdSelA = FWD_E2;
        else if (writes(mRes, exOp.rsAddr))
            fwdSelA = FWD_M;
        else if (writes(wRes, exOp.rsAddr))
            fwdSelA = FWD_W;

        if (writes(e2Res, exOp.rtAddr))
            fwdSelB = FWD_E2;
        else if (writes(mRes, exOp.rtAddr))
            fwdSelB = FWD_M;
        else if (writes(wRes, exOp.rtAddr))
            fwdSelB = FWD_W;

        bypassA = writes(wRes, decRsAddr);  // Regfile write lands at end of cycle
        bypassB = writes(wRes, decRtAddr);
    end

    // No source select ever points at register 0
    always_comb
    begin
        assert (!(((fwdSelA != FWD_REG) && (exOp.rsAddr == '0)) ||
                  ((fwdSelB != FWD_REG) && (exOp.rtAddr == '0)) ||
                  (bypassA && (decRsAddr == '0)) || (bypassB && (decRtAddr == '0))))
            else $error("forwardUnit: forward raised for register 0");
    end

endmodule

/* verilog/regFile.sv */
// regFile
// Register file with two combinational read ports and
// one write port. Register 0 is never written

`timescale 1ns/1ps
`include "core_settings.svh"

module regFile (
    input  logic            clock,
    input  logic            arstN,
    input  isaPkg::regAddrT rdAddrA,
    input  isaPkg::regAddrT rdAddrB,
    output isaPkg::wordT    rdDataA,
    output isaPkg::wordT    rdDataB,
    input  logic            wrEn,
    input  isaPkg::regAddrT wrAddr,
    input  isaPkg::wordT    wrData
);
    import isaPkg::*;

    wordT regs [`CORE_NREGS];

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `CORE_NREGS; i++)
                regs[i] <= '0;
        end
        else if (wrEn && (wrAddr != '0))  // Register 0 stays zero
            regs[wrAddr] <= wrData;
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    // Register 0 reads zero on both ports at all times
    a_zeroReg: assert property (@(posedge clock) disable iff (!arstN)
        ((rdAddrA == '0) |-> (rdDataA == '0)) and ((rdAddrB == '0) |-> (rdDataB == '0)))
        else $error("regFile: register 0 read nonzero");

endmodule

/* verilog/pipePkg.sv */
// pipePkg
// Payloads carried between pipeline stages and the
// operand source select used by forwarding

package pipePkg;

    // Operand source for E1 ----------------
    typedef logic [1:0] fwdSelT;

    localparam fwdSelT FWD_REG = 2'b00;  // Value captured in decode
    localparam fwdSelT FWD_E2  = 2'b01;
    localparam fwdSelT FWD_M   = 2'b10;
    localparam fwdSelT FWD_W   = 2'b11;

    // Decoded instruction, D to E1
    typedef struct packed {
        logic            valid;
        isaPkg::aluOpT   aluOp;
        logic            useImm;    // Operand B from imm
        isaPkg::wordT    imm;       // Already extended
        isaPkg::regAddrT rsAddr;
        isaPkg::regAddrT rtAddr;
        isaPkg::wordT    rsData;
        isaPkg::wordT    rtData;
        logic            writeEn;   // Low for rd 0 or unknown code
        isaPkg::regAddrT destAddr;
    } decodedOpT;

    // Result carried through E2, M and W
    typedef struct packed {
        logic            valid;
        logic            writeEn;
        isaPkg::regAddrT destAddr;
        isaPkg::wordT    data;
    } resultT;

endpackage

/* verilog/isaPkg.sv */
// isaPkg
// Instruction encoding for the MIPS-like subset. Field types,
// opcode and function codes, and the ALU operation codes

`include "core_settings.svh"

package isaPkg;

    typedef logic [`CORE_XLEN-1:0]          wordT;
    typedef logic [$clog2(`CORE_NREGS)-1:0] regAddrT;
    typedef logic [31:0]                    instrT;
    typedef logic [5:0]                     opcodeT;
    typedef logic [5:0]                     functT;
    typedef logic [15:0]                    immT;
    typedef logic [3:0]                     aluOpT;

    // Opcodes ------------------------------
    localparam opcodeT OP_RTYPE = 6'h00;
    localparam opcodeT OP_ADDI  = 6'h08;
    localparam opcodeT OP_SLTI  = 6'h0A;
    localparam opcodeT OP_ANDI  = 6'h0C;
    localparam opcodeT OP_ORI   = 6'h0D;
    localparam opcodeT OP_XORI  = 6'h0E;
    localparam opcodeT OP_LUI   = 6'h0F;

    // R-type function field ----------------
    localparam functT FN_ADD = 6'h20;
    localparam functT FN_SUB = 6'h22;
    localparam functT FN_AND = 6'h24;
    localparam functT FN_OR  = 6'h25;
    localparam functT FN_XOR = 6'h26;
    localparam functT FN_NOR = 6'h27;
    localparam functT FN_SLT = 6'h2A;

    // ALU operations
    localparam aluOpT ALU_ADD = 4'd0;
    localparam aluOpT ALU_SUB = 4'd1;
    localparam aluOpT ALU_AND = 4'd2;
    localparam aluOpT ALU_OR  = 4'd3;
    localparam aluOpT ALU_XOR = 4'd4;
    localparam aluOpT ALU_NOR = 4'd5;
    localparam aluOpT ALU_SLT = 4'd6;
    localparam aluOpT ALU_LUI = 4'd7;  // Immediate into upper half

endpackage

/* verilog/core_settings.svh */
// Core settings
// Global sizes and pipeline latency shared by the
// RTL and the testbench

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_XLEN       32  // Data word width
`define CORE_NREGS      32  // Architectural registers

// Strobe edge to wbStrobe, in cycles
`define CORE_WB_LATENCY 5

`endif
